//--- accumulatorUnit.sv
// Accumulator, link and operate logic
`default_nettype none

module accumulatorUnit (
  input  logic           clk,
  input  logic           rstN,
  input  logic           acLoad,
  input  pdp8Pkg::acSelT acSel,
  input  pdp8Pkg::wordT  memRdata,
  input  logic           oprCla,
  input  logic           oprCll,
  input  logic           oprCma,
  input  logic           oprCml,
  input  logic           oprIac,
  input  logic           oprRotRight,
  input  logic           oprRotLeft,
  input  logic           oprTwice,
  input  logic           oprSkipSma,
  input  logic           oprSkipSza,
  input  logic           oprSkipSnl,
  input  logic           oprSkipInv,
  input  logic           isOprGroup2,
  output pdp8Pkg::wordT  acc,
  output logic           link,
  output logic           skipTaken
);
  import pdp8Pkg::*;

  wordT              sum;
  logic              carry;
  wordT              claOut;
  wordT              cmaOut;
  logic              cllOut;
  logic              cmlOut;
  logic [WordBits:0] incOut;
  logic [WordBits:0] rotOut;
  logic              skipAny;

  // Link and accumulator rotate as one 13-bit ring
  function automatic logic [WordBits:0] rotRight(input logic [WordBits:0] v);
    return {v[0], v[WordBits:1]};
  endfunction

  function automatic logic [WordBits:0] rotLeft(input logic [WordBits:0] v);
    return {v[WordBits-1:0], v[WordBits]};
  endfunction

  // TAD adder, carry out toggles the link
  assign {carry, sum} = {1'b0, acc} + {1'b0, memRdata};

  // Operate chain: clear, complement, increment, rotate
  assign claOut = oprCla ? '0 : acc;
  assign cllOut = oprCll ? 1'b0 : link;
  assign cmaOut = oprCma ? ~claOut : claOut;
  assign cmlOut = oprCml ? ~cllOut : cllOut;
  // IAC overflow carries into the link
  assign incOut = {cmlOut, cmaOut} + {{WordBits{1'b0}}, oprIac};

  always_comb begin
    rotOut = incOut;
    if (oprRotRight) begin
      rotOut = oprTwice ? rotRight(rotRight(incOut)) : rotRight(incOut);
    end else if (oprRotLeft) begin
      rotOut = oprTwice ? rotLeft(rotLeft(incOut)) : rotLeft(incOut);
    end else if (oprTwice) begin
      // BSW, link untouched
      rotOut = {incOut[WordBits], incOut[WordBits/2-1:0], incOut[WordBits-1:WordBits/2]};
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      acc  <= '0;
      link <= 1'b0;
    end else if (acLoad) begin
      case (acSel)
        selAdd: begin
          acc  <= sum;
          link <= link ^ carry;
        end
        selAnd: acc <= acc & memRdata;
        selOpr: {link, acc} <= rotOut;
        selClr: acc <= '0;
        default: acc <= acc;
      endcase
    end
  end

  // Group 2 test on the values before CLA
  assign skipAny = (oprSkipSma && acc[WordBits-1])
                || (oprSkipSza && (acc == '0))
                || (oprSkipSnl && link);
  // Inverted sense gives SPA, SNA, SZL and plain SKP
  assign skipTaken = isOprGroup2 && (oprSkipInv ? !skipAny : skipAny);

endmodule

`default_nettype wire

//--- cpuSequencer.sv
// Major-state sequencer
`default_nettype none

module cpuSequencer (
  input  logic            clk,
  input  logic            rstN,
  input  logic            run,
  input  pdp8Pkg::opcodeT opcode,
  input  logic            indirect,
  input  logic            isOprGroup2,
  input  logic            oprHlt,
  input  pdp8Pkg::wordT   effAddr,
  input  pdp8Pkg::wordT   acc,
  input  logic            skipTaken,
  input  logic            memDone,
  input  pdp8Pkg::wordT   memRdata,
  output logic            memReq,
  output logic            memWrite,
  output pdp8Pkg::wordT   memAddr,
  output pdp8Pkg::wordT   memWdata,
  output logic            loadIr,
  output logic            loadPointer,
  output logic            acLoad,
  output pdp8Pkg::acSelT  acSel,
  output pdp8Pkg::wordT   pc,
  output pdp8Pkg::wordT   pcPage,
  output logic            halted,
  output logic            instDone
);
  import pdp8Pkg::*;

  seqStateT state;
  seqStateT stateNext;
  wordT     pcNext;
  wordT     iszSum;
  logic     needMem;
  logic     pending;
  logic     haltSet;

  // Stores go through stExecWrite, loads through stExecRead
  function automatic seqStateT execEntry(input opcodeT op);
    return (op == opDca || op == opJms) ? stExecWrite : stExecRead;
  endfunction

  // ISZ result, operand still held from the read
  assign iszSum = memRdata + 12'd1;

  // Memory cycle of each state
  always_comb begin
    needMem  = 1'b0;
    memWrite = 1'b0;
    memAddr  = effAddr;
    memWdata = acc;
    case (state)
      stFetch: begin
        // Idle until run is raised
        needMem = run;
        memAddr = pc;
      end
      stDefer:    needMem = 1'b1;
      stExecRead: needMem = 1'b1;
      stExecWrite: begin
        needMem  = 1'b1;
        memWrite = 1'b1;
        if (opcode == opJms) begin
          memWdata = pc;
        end else if (opcode == opIsz) begin
          memWdata = iszSum;
        end
      end
      default: needMem = 1'b0;
    endcase
  end

  // One request per memory cycle
  assign memReq = needMem && !pending;

  always_comb begin
    stateNext   = state;
    pcNext      = pc;
    loadIr      = 1'b0;
    loadPointer = 1'b0;
    acLoad      = 1'b0;
    acSel       = selOpr;
    instDone    = 1'b0;
    haltSet     = 1'b0;
    case (state)
      stFetch: begin
        if (memDone) begin
          loadIr    = 1'b1;
          pcNext    = pc + 12'd1;
          stateNext = stDecode;
        end
      end
      stDecode: begin
        if (opcode == opIot) begin
          // IOT words do nothing
          instDone  = 1'b1;
          stateNext = stFetch;
        end else if (opcode == opOpr) begin
          stateNext = stOperate;
        end else if (indirect) begin
          stateNext = stDefer;
        end else if (opcode == opJmp) begin
          pcNext    = effAddr;
          instDone  = 1'b1;
          stateNext = stFetch;
        end else begin
          stateNext = execEntry(opcode);
        end
      end
      stDefer: begin
        if (memDone && opcode == opJmp) begin
          // JMP I takes the pointer straight from the bus
          pcNext    = memRdata;
          instDone  = 1'b1;
          stateNext = stFetch;
        end else if (memDone) begin
          loadPointer = 1'b1;
          stateNext   = execEntry(opcode);
        end
      end
      stExecRead: begin
        if (memDone && opcode == opIsz) begin
          stateNext = stExecWrite;
        end else if (memDone) begin
          acLoad      = 1'b1;
          acSel       = (opcode == opTad) ? selAdd : selAnd;
          loadPointer = indirect;
          instDone    = 1'b1;
          stateNext   = stFetch;
        end
      end
      stExecWrite: begin
        if (memDone) begin
          loadPointer = indirect;
          instDone    = 1'b1;
          stateNext   = stFetch;
          if (opcode == opDca) begin
            acLoad = 1'b1;
            acSel  = selClr;
          end else if (opcode == opJms) begin
            pcNext = effAddr + 12'd1;
          end else if (iszSum == '0) begin
            pcNext = pc + 12'd1;
          end
        end
      end
      stOperate: begin
        acLoad   = 1'b1;
        instDone = 1'b1;
        if (skipTaken) begin
          pcNext = pc + 12'd1;
        end
        haltSet   = isOprGroup2 && oprHlt;
        stateNext = haltSet ? stHalt : stFetch;
      end
      default: stateNext = state;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state   <= stFetch;
      pending <= 1'b0;
      pc      <= StartAddr;
      pcPage  <= StartAddr;
      halted  <= 1'b0;
    end else begin
      state <= stateNext;
      pc    <= pcNext;
      if (memReq) begin
        pending <= 1'b1;
      end else if (memDone) begin
        pending <= 1'b0;
      end
      // Address of the instruction now in the IR
      if (loadIr) begin
        pcPage <= pc;
      end
      if (haltSet) begin
        halted <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+.
pdp8Pkg.sv
memRequester.sv
instDecode.sv
operandAddress.sv
accumulatorUnit.sv
cpuSequencer.sv
pdp8Cpu.sv
pdp8Tb.sv

//--- instDecode.sv
// Instruction register and decoder
`default_nettype none

module instDecode (
  input  logic            clk,
  input  logic            rstN,
  input  logic            loadIr,
  input  pdp8Pkg::wordT   memRdata,
  output pdp8Pkg::wordT   ir,
  output pdp8Pkg::opcodeT opcode,
  output logic            indirect,
  output logic            isOprGroup2,
  output logic            oprCla,
  output logic            oprCll,
  output logic            oprCma,
  output logic            oprCml,
  output logic            oprIac,
  output logic            oprRotRight,
  output logic            oprRotLeft,
  output logic            oprTwice,
  output logic            oprSkipSma,
  output logic            oprSkipSza,
  output logic            oprSkipSnl,
  output logic            oprSkipInv,
  output logic            oprHlt
);
  import pdp8Pkg::*;

  logic isOpr;
  logic isGroup1;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      ir <= '0;
    end else if (loadIr) begin
      ir <= memRdata;
    end
  end

  assign opcode   = opcodeT'(ir[WordBits-1:WordBits-3]);
  assign indirect = ir[IndirectBit];

  assign isOpr    = (opcode == opOpr);
  assign isGroup1 = isOpr && !ir[OprGroupBit];
  // Group 3 words match neither group and act as no-ops
  assign isOprGroup2 = isOpr && ir[OprGroupBit] && !ir[OprGroup3Bit];

  // CLA sits at the same place in both groups
  assign oprCla = (isGroup1 || isOprGroup2) && ir[OprClaBit];

  // Group 1 fields, zero outside group 1
  assign oprCll      = isGroup1 && ir[OprCllBit];
  assign oprCma      = isGroup1 && ir[OprCmaBit];
  assign oprCml      = isGroup1 && ir[OprCmlBit];
  assign oprIac      = isGroup1 && ir[OprIacBit];
  assign oprRotRight = isGroup1 && ir[OprRarBit];
  assign oprRotLeft  = isGroup1 && ir[OprRalBit];
  // Rotate twice, or BSW when no rotate is set
  assign oprTwice    = isGroup1 && ir[OprTwiceBit];

  // Group 2 fields share bits 6..1 with group 1
  assign oprSkipSma = isOprGroup2 && ir[OprSmaBit];
  assign oprSkipSza = isOprGroup2 && ir[OprSzaBit];
  assign oprSkipSnl = isOprGroup2 && ir[OprSnlBit];
  assign oprSkipInv = isOprGroup2 && ir[OprSkipInvBit];
  assign oprHlt     = isOprGroup2 && ir[OprHltBit];

endmodule

`default_nettype wire

//--- memRequester.sv
// APB memory requester
`default_nettype none

module memRequester (
  input  logic          clk,
  input  logic          rstN,
  input  logic          memReq,
  input  logic          memWrite,
  input  pdp8Pkg::wordT memAddr,
  input  pdp8Pkg::wordT memWdata,
  input  pdp8Pkg::wordT prdata,
  input  logic          pready,
  output pdp8Pkg::wordT paddr,
  output logic          psel,
  output logic          penable,
  output logic          pwrite,
  output pdp8Pkg::wordT pwdata,
  output logic          memDone,
  output pdp8Pkg::wordT memRdata
);

  // APB transfer phases
  typedef enum logic [1:0] {
    apbIdle,
    apbSetup,
    apbAccess
  } apbStateT;

  apbStateT apbState;
  logic     xferEnd;

  // Access phase with the completer ready
  assign xferEnd = (apbState == apbAccess) && pready;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      apbState <= apbIdle;
      memDone  <= 1'b0;
    end else begin
      memDone <= xferEnd;
      case (apbState)
        apbIdle:   if (memReq) apbState <= apbSetup;
        apbSetup:  apbState <= apbAccess;
        apbAccess: if (pready) apbState <= apbIdle;
        default:   apbState <= apbIdle;
      endcase
    end
  end

  // Address, direction and data frozen from setup to completion
  always_ff @(posedge clk) begin
    if (apbState == apbIdle && memReq) begin
      paddr  <= memAddr;
      pwrite <= memWrite;
      pwdata <= memWdata;
    end
    // Read data held until the next read ends
    if (xferEnd && !pwrite) begin
      memRdata <= prdata;
    end
  end

  assign psel    = (apbState != apbIdle);
  assign penable = (apbState == apbAccess);

endmodule

`default_nettype wire

//--- operandAddress.sv
// Effective address stage
`default_nettype none

module operandAddress (
  input  logic          clk,
  input  logic          rstN,
  input  pdp8Pkg::wordT ir,
  input  pdp8Pkg::wordT pcPage,
  input  logic          loadPointer,
  input  pdp8Pkg::wordT memRdata,
  output pdp8Pkg::wordT effAddr
);
  import pdp8Pkg::*;

  logic [WordBits-PageBits-1:0] pageBase;
  wordT                         directAddr;
  wordT                         pointer;
  logic                         pointerValid;

  // Page zero, or the page holding the instruction itself
  assign pageBase   = ir[PageSelBit] ? pcPage[WordBits-1:PageBits] : '0;
  assign directAddr = {pageBase, ir[PageBits-1:0]};

  // First pulse takes the pointer after the defer read
  // Second pulse, at the end of the instruction, releases it
  always_ff @(posedge clk) begin
    if (!rstN) begin
      pointerValid <= 1'b0;
    end else if (loadPointer) begin
      pointerValid <= !pointerValid;
    end
  end

  always_ff @(posedge clk) begin
    if (loadPointer && !pointerValid) begin
      pointer <= memRdata;
    end
  end

  // Indirect operand once the pointer is held
  assign effAddr = pointerValid ? pointer : directAddr;

endmodule

`default_nettype wire

//--- pdp8Cpu.sv
// PDP-8 processor top
`default_nettype none

module pdp8Cpu (
  input  logic          clk,
  input  logic          rstN,
  input  logic          run,
  input  pdp8Pkg::wordT prdata,
  input  logic          pready,
  output pdp8Pkg::wordT paddr,
  output logic          psel,
  output logic          penable,
  output logic          pwrite,
  output pdp8Pkg::wordT pwdata,
  output pdp8Pkg::wordT acc,
  output logic          link,
  output pdp8Pkg::wordT pc,
  output logic          halted,
  output logic          instDone
);
  import pdp8Pkg::*;

  // Sequencer to memory port
  logic   memReq;
  logic   memWrite;
  wordT   memAddr;
  wordT   memWdata;
  logic   memDone;
  wordT   memRdata;

  // Stage controls
  logic   loadIr;
  logic   loadPointer;
  logic   acLoad;
  acSelT  acSel;
  wordT   pcPage;
  wordT   effAddr;
  logic   skipTaken;

  // Decoded instruction
  wordT   ir;
  opcodeT opcode;
  logic   indirect;
  logic   isOprGroup2;
  logic   oprCla;
  logic   oprCll;
  logic   oprCma;
  logic   oprCml;
  logic   oprIac;
  logic   oprRotRight;
  logic   oprRotLeft;
  logic   oprTwice;
  logic   oprSkipSma;
  logic   oprSkipSza;
  logic   oprSkipSnl;
  logic   oprSkipInv;
  logic   oprHlt;

  memRequester memRequester_inst (
    .clk(clk), .rstN(rstN),
    .memReq(memReq), .memWrite(memWrite), .memAddr(memAddr), .memWdata(memWdata),
    .prdata(prdata), .pready(pready),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
    .memDone(memDone), .memRdata(memRdata)
  );

  instDecode instDecode_inst (
    .clk(clk), .rstN(rstN), .loadIr(loadIr), .memRdata(memRdata),
    .ir(ir), .opcode(opcode), .indirect(indirect), .isOprGroup2(isOprGroup2),
    .oprCla(oprCla), .oprCll(oprCll), .oprCma(oprCma), .oprCml(oprCml),
    .oprIac(oprIac), .oprRotRight(oprRotRight), .oprRotLeft(oprRotLeft),
    .oprTwice(oprTwice), .oprSkipSma(oprSkipSma), .oprSkipSza(oprSkipSza),
    .oprSkipSnl(oprSkipSnl), .oprSkipInv(oprSkipInv), .oprHlt(oprHlt)
  );

  operandAddress operandAddress_inst (
    .clk(clk), .rstN(rstN), .ir(ir), .pcPage(pcPage),
    .loadPointer(loadPointer), .memRdata(memRdata), .effAddr(effAddr)
  );

  accumulatorUnit accumulatorUnit_inst (
    .clk(clk), .rstN(rstN), .acLoad(acLoad), .acSel(acSel), .memRdata(memRdata),
    .oprCla(oprCla), .oprCll(oprCll), .oprCma(oprCma), .oprCml(oprCml),
    .oprIac(oprIac), .oprRotRight(oprRotRight), .oprRotLeft(oprRotLeft),
    .oprTwice(oprTwice), .oprSkipSma(oprSkipSma), .oprSkipSza(oprSkipSza),
    .oprSkipSnl(oprSkipSnl), .oprSkipInv(oprSkipInv), .isOprGroup2(isOprGroup2),
    .acc(acc), .link(link), .skipTaken(skipTaken)
  );

  cpuSequencer cpuSequencer_inst (
    .clk(clk), .rstN(rstN), .run(run),
    .opcode(opcode), .indirect(indirect), .isOprGroup2(isOprGroup2), .oprHlt(oprHlt),
    .effAddr(effAddr), .acc(acc), .skipTaken(skipTaken),
    .memDone(memDone), .memRdata(memRdata),
    .memReq(memReq), .memWrite(memWrite), .memAddr(memAddr), .memWdata(memWdata),
    .loadIr(loadIr), .loadPointer(loadPointer), .acLoad(acLoad), .acSel(acSel),
    .pc(pc), .pcPage(pcPage), .halted(halted), .instDone(instDone)
  );

endmodule

`default_nettype wire

//--- pdp8Pkg.sv
// PDP-8 shared definitions
`default_nettype none

package pdp8Pkg;

  // Word and memory-reference address fields
  localparam int WordBits    = 12;
  localparam int PageBits    = 7;
  localparam int PageSelBit  = 7;
  localparam int IndirectBit = 8;

  typedef logic [WordBits-1:0] wordT;

  // First instruction after reset, 0200 octal
  localparam wordT StartAddr = 12'o0200;

  // Major opcode, instruction bits 11..9
  typedef enum logic [2:0] {
    opAnd,
    opTad,
    opIsz,
    opDca,
    opJms,
    opJmp,
    opIot,
    opOpr
  } opcodeT;

  // Major states of the instruction sequencer
  typedef enum logic [2:0] {
    stFetch,
    stDecode,
    stDefer,
    stExecRead,
    stExecWrite,
    stOperate,
    stHalt
  } seqStateT;

  // Source of the next accumulator value
  typedef enum logic [1:0] {
    selAdd,
    selAnd,
    selOpr,
    selClr
  } acSelT;

  // Operate word layout
  localparam int OprGroupBit   = 8;
  localparam int OprGroup3Bit  = 0;
  localparam int OprClaBit     = 7;
  // Group 1 microinstructions
  localparam int OprCllBit     = 6;
  localparam int OprCmaBit     = 5;
  localparam int OprCmlBit     = 4;
  localparam int OprRarBit     = 3;
  localparam int OprRalBit     = 2;
  localparam int OprTwiceBit   = 1;
  localparam int OprIacBit     = 0;
  // Group 2 skips and halt
  localparam int OprSmaBit     = 6;
  localparam int OprSzaBit     = 5;
  localparam int OprSnlBit     = 4;
  localparam int OprSkipInvBit = 3;
  localparam int OprHltBit     = 1;

endpackage

`default_nettype wire

//--- pdp8RefModel.svh
// PDP-8 reference interpreter
`ifndef PDP8_REF_MODEL_SVH
`define PDP8_REF_MODEL_SVH

// Runs from StartAddr until HLT or stepLimit instructions
// Returns 1 when a HLT stopped the program
// stepsOut counts the instructions run, the HLT included
function automatic bit pdp8RefRun(
  ref    pdp8Pkg::wordT mem [0:4095],
  input  int            stepLimit,
  output pdp8Pkg::wordT acOut,
  output logic          linkOut,
  output pdp8Pkg::wordT pcOut,
  output int            stepsOut
);
  pdp8Pkg::wordT ir;
  pdp8Pkg::wordT cur;
  pdp8Pkg::wordT addr;
  logic [12:0]   lac;
  logic          cond;
  bit            stop;
  int            turns;

  // Link in bit 12, accumulator below it
  lac      = '0;
  pcOut    = pdp8Pkg::StartAddr;
  stop     = 1'b0;
  stepsOut = 0;
  for (int step = 0; step < stepLimit && !stop; step++) begin
    stepsOut++;
    cur   = pcOut;
    ir    = mem[cur];
    pcOut = cur + 12'd1;
    // Page zero or current page, single indirection, no auto-index
    addr = {ir[7] ? cur[11:7] : 5'd0, ir[6:0]};
    if (ir[11:9] < 3'd6 && ir[8]) addr = mem[addr];
    case (ir[11:9])
      3'd0: lac[11:0] = lac[11:0] & mem[addr];
      // Carry into bit 12 complements the link
      3'd1: lac = lac + {1'b0, mem[addr]};
      3'd2: begin
        mem[addr] = mem[addr] + 12'd1;
        if (mem[addr] == '0) pcOut = pcOut + 12'd1;
      end
      3'd3: begin
        mem[addr] = lac[11:0];
        lac[11:0] = '0;
      end
      3'd4: begin
        mem[addr] = pcOut;
        pcOut     = addr + 12'd1;
      end
      3'd5: pcOut = addr;
      3'd7: begin
        if (!ir[8]) begin
          if (ir[7]) lac[11:0] = '0;
          if (ir[6]) lac[12] = 1'b0;
          if (ir[5]) lac[11:0] = ~lac[11:0];
          if (ir[4]) lac[12] = ~lac[12];
          if (ir[0]) lac = lac + 13'd1;
          turns = ir[1] ? 2 : 1;
          for (int k = 0; k < turns; k++) begin
            if (ir[3]) lac = {lac[0], lac[12:1]};
            else if (ir[2]) lac = {lac[11:0], lac[12]};
          end
          if (ir[3:1] == 3'b001) lac[11:0] = {lac[5:0], lac[11:6]};
        end else if (!ir[0]) begin
          // Skips test the values before CLA
          cond = (ir[6] && lac[11]) || (ir[5] && lac[11:0] == '0) || (ir[4] && lac[12]);
          if (ir[3]) cond = !cond;
          if (cond) pcOut = pcOut + 12'd1;
          if (ir[7]) lac[11:0] = '0;
          if (ir[1]) stop = 1'b1;
        end
      end
      // IOT and group 3 do nothing
      default: stop = stop;
    endcase
  end
  acOut   = lac[11:0];
  linkOut = lac[12];
  return stop;
endfunction

`endif

//--- pdp8Tb.sv
// PDP-8 processor testbench
`default_nettype none

module pdp8Tb;
  import pdp8Pkg::*;

  `include "pdp8RefModel.svh"

  // Reset test plus four programs, each run twice
  localparam int NumRuns    = 9;
  localparam int CycleLimit = NumRuns * 2000;
  localparam int StepLimit  = 1000;

  logic clk = 1'b0;
  logic rstN;
  logic run;
  wordT prdata = '0;
  logic pready = 1'b0;
  wordT paddr;
  logic psel;
  logic penable;
  logic pwrite;
  wordT pwdata;
  wordT acc;
  logic link;
  wordT pc;
  logic halted;
  logic instDone;

  // Memory behind the APB port and the image it is loaded from
  wordT mem    [0:4095];
  wordT image  [0:4095];
  wordT refMem [0:4095];
  logic loadMem;
  bit   randomWaits;

  // Completer state
  integer seed = 32'hea1e;
  int     waitLeft = 0;
  wordT   holdAddr;
  logic   holdWrite;
  wordT   holdWdata;

  // Expected state from the reference model
  wordT  expAcc;
  logic  expLink;
  wordT  expPc;
  bit    expHalt;
  int    expSteps;

  int    cycleCount = 0;
  int    doneCount = 0;
  int    mainErrs = 0;
  int    checkErrs = 0;
  int    waitErrs = 0;
  int    passCount = 0;
  int    failCount = 0;
  int    compareCount = 0;
  string curName = "none";

  event compareStart;

  pdp8Cpu pdp8Cpu_inst (
    .clk(clk), .rstN(rstN), .run(run), .prdata(prdata), .pready(pready),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
    .acc(acc), .link(link), .pc(pc), .halted(halted), .instDone(instDone)
  );

  always #5 clk = ~clk;

  // APB completer with optional random wait states
  always @(posedge clk) begin
    int w;
    if (loadMem) begin
      for (int a = 0; a < 4096; a++) begin
        mem[12'(a)] <= image[12'(a)];
      end
    end
    if (!rstN) begin
      pready    <= 1'b0;
      waitLeft  <= 0;
    end else if (psel && !penable) begin
      // Setup phase, remember what must stay frozen
      holdAddr  <= paddr;
      holdWrite <= pwrite;
      holdWdata <= pwdata;
      prdata    <= mem[paddr];
      w = randomWaits ? int'({$random(seed)} % 32'd4) : 0;
      waitLeft  <= w;
      pready    <= (w == 0);
    end else if (psel && penable) begin
      assert (paddr == holdAddr && pwrite == holdWrite && pwdata == holdWdata) else begin
        $display("FAIL %0t: %s APB request changed during a transfer", $time, curName);
        waitErrs++;
      end
      if (pready) begin
        if (pwrite) begin
          mem[paddr] <= pwdata;
        end
        pready    <= 1'b0;
      end else begin
        waitLeft <= waitLeft - 1;
        pready   <= (waitLeft == 1);
      end
    end
  end

  // Instructions finished since the last reset
  always @(posedge clk) begin
    if (!rstN) begin
      doneCount <= 0;
    end else if (instDone) begin
      doneCount <= doneCount + 1;
    end
  end

  // Hang guard over the whole run
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CycleLimit) begin
      $display("Timeout: program %s did not halt within %0d cycles", curName, CycleLimit);
      $display("TEST FAILED");
      $finish;
    end
  end

  // Final state against the reference interpreter
  always @(compareStart) begin
    refMem  = image;
    expHalt = pdp8RefRun(refMem, StepLimit, expAcc, expLink, expPc, expSteps);
    assert (expHalt) else begin
      $display("Reference model for %s never reached a HLT", curName);
      checkErrs++;
    end
    assert (acc == expAcc) else begin
      $display("FAIL %0t: %s acc %o, expected %o", $time, curName, acc, expAcc);
      checkErrs++;
    end
    assert (link == expLink) else begin
      $display("FAIL %0t: %s link %b, expected %b", $time, curName, link, expLink);
      checkErrs++;
    end
    assert (pc == expPc) else begin
      $display("FAIL %0t: %s pc %o, expected %o", $time, curName, pc, expPc);
      checkErrs++;
    end
    // One instDone pulse per instruction
    assert (doneCount == expSteps) else begin
      $display("FAIL %0t: %s %0d instructions done, expected %0d", $time, curName,
               doneCount, expSteps);
      checkErrs++;
    end
    for (int a = 0; a < 4096; a++) begin
      assert (mem[12'(a)] == refMem[12'(a)]) else begin
        $display("FAIL %0t: %s mem[%o] = %o, expected %o", $time, curName, 12'(a),
                 mem[12'(a)], refMem[12'(a)]);
        checkErrs++;
      end
    end
    compareCount++;
  end

  task automatic storeWord(input wordT addr, input wordT word);
    image[addr] = word;
  endtask

  // Arithmetic and store with every addressing mode
  task automatic programArith();
    storeWord(12'o0200, 12'o7300);
    storeWord(12'o0201, 12'o1250);
    storeWord(12'o0202, 12'o1020);
    storeWord(12'o0203, 12'o3251);
    storeWord(12'o0204, 12'o1652);
    storeWord(12'o0205, 12'o0253);
    storeWord(12'o0206, 12'o3654);
    // 7777 plus 1 overflows into the link
    storeWord(12'o0207, 12'o1255);
    storeWord(12'o0210, 12'o1256);
    // Pointer in 0012 acts as plain indirect
    storeWord(12'o0211, 12'o1412);
    storeWord(12'o0212, 12'o7402);
    storeWord(12'o0250, 12'o3456);
    storeWord(12'o0020, 12'o1234);
    storeWord(12'o0252, 12'o0030);
    storeWord(12'o0030, 12'o5555);
    storeWord(12'o0253, 12'o0707);
    storeWord(12'o0254, 12'o0031);
    storeWord(12'o0255, 12'o7777);
    storeWord(12'o0256, 12'o0001);
    storeWord(12'o0257, 12'o0123);
    storeWord(12'o0012, 12'o0257);
  endtask

  // ISZ loop, JMS direct and indirect, JMP I return
  task automatic programControl();
    storeWord(12'o0200, 12'o7300);
    storeWord(12'o0201, 12'o1260);
    storeWord(12'o0202, 12'o3261);
    storeWord(12'o0203, 12'o2261);
    storeWord(12'o0204, 12'o5203);
    storeWord(12'o0205, 12'o4270);
    storeWord(12'o0206, 12'o1262);
    storeWord(12'o0207, 12'o4664);
    storeWord(12'o0210, 12'o7402);
    // Count of minus five
    storeWord(12'o0260, 12'o7773);
    storeWord(12'o0262, 12'o0042);
    storeWord(12'o0263, 12'o7777);
    storeWord(12'o0264, 12'o0300);
    // Subroutine at 0270, ISZ skips the HLT
    storeWord(12'o0271, 12'o7001);
    storeWord(12'o0272, 12'o2263);
    storeWord(12'o0273, 12'o7402);
    storeWord(12'o0274, 12'o5670);
    // Subroutine at 0300 reached through a pointer
    storeWord(12'o0301, 12'o7040);
    storeWord(12'o0302, 12'o5700);
  endtask

  // Group 1 chains, rotates, BSW and no-op words
  task automatic programGroup1();
    storeWord(12'o0200, 12'o7300);
    storeWord(12'o0201, 12'o1240);
    storeWord(12'o0202, 12'o7004);
    storeWord(12'o0203, 12'o7012);
    storeWord(12'o0204, 12'o7030);
    storeWord(12'o0205, 12'o7006);
    storeWord(12'o0206, 12'o7002);
    storeWord(12'o0207, 12'o3241);
    // IAC on 7777 carries into the link
    storeWord(12'o0210, 12'o7240);
    storeWord(12'o0211, 12'o7101);
    storeWord(12'o0212, 12'o3242);
    storeWord(12'o0213, 12'o7365);
    storeWord(12'o0214, 12'o3243);
    storeWord(12'o0215, 12'o1244);
    storeWord(12'o0216, 12'o7023);
    // Group 3 and IOT words do nothing
    storeWord(12'o0217, 12'o7421);
    storeWord(12'o0220, 12'o6046);
    storeWord(12'o0221, 12'o7402);
    storeWord(12'o0240, 12'o4321);
    storeWord(12'o0244, 12'o0077);
  endtask

  // Each skip and its inverse, ISZ markers show which ran
  task automatic programGroup2();
    for (int a = 'o240; a <= 'o251; a++) begin
      storeWord(12'(a), '0);
    end
    storeWord(12'o0200, 12'o7300);
    storeWord(12'o0201, 12'o1270);
    storeWord(12'o0202, 12'o7500);
    storeWord(12'o0203, 12'o2240);
    storeWord(12'o0204, 12'o7510);
    storeWord(12'o0205, 12'o2241);
    storeWord(12'o0206, 12'o7440);
    storeWord(12'o0207, 12'o2242);
    storeWord(12'o0210, 12'o7450);
    storeWord(12'o0211, 12'o2243);
    storeWord(12'o0212, 12'o7420);
    storeWord(12'o0213, 12'o2244);
    storeWord(12'o0214, 12'o7430);
    storeWord(12'o0215, 12'o2245);
    // Zero accumulator with the link set
    storeWord(12'o0216, 12'o7220);
    storeWord(12'o0217, 12'o7460);
    storeWord(12'o0220, 12'o2246);
    storeWord(12'o0221, 12'o7470);
    storeWord(12'o0222, 12'o2247);
    storeWord(12'o0223, 12'o7410);
    storeWord(12'o0224, 12'o2250);
    storeWord(12'o0225, 12'o1271);
    // Skip tests before the clear
    storeWord(12'o0226, 12'o7640);
    storeWord(12'o0227, 12'o2251);
    storeWord(12'o0230, 12'o1272);
    storeWord(12'o0231, 12'o7602);
    storeWord(12'o0270, 12'o4000);
    storeWord(12'o0271, 12'o0123);
    storeWord(12'o0272, 12'o0055);
  endtask

  task automatic loadImage(input int id);
    // Background depends on every address bit
    for (int a = 0; a < 4096; a++) begin
      image[12'(a)] = 12'(a * 5 + 3);
    end
    case (id)
      1: programArith();
      2: programControl();
      3: programGroup1();
      default: programGroup2();
    endcase
  endtask

  // Eight cycles of reset, memory copied from the image
  task automatic resetCpu();
    @(posedge clk);
    rstN    <= 1'b0;
    run     <= 1'b0;
    loadMem <= 1'b1;
    @(posedge clk);
    loadMem <= 1'b0;
    repeat (7) @(posedge clk);
    rstN <= 1'b1;
  endtask

  task automatic reportTest(input int errBefore);
    if (mainErrs + checkErrs + waitErrs == errBefore) begin
      $display("PASS %s", curName);
      passCount++;
    end else begin
      $display("FAIL %0t: test %s had errors", $time, curName);
      failCount++;
    end
  endtask

  task automatic runProgram(input string name, input int id, input bit waits);
    int errBefore;
    int doneBefore;
    errBefore   = mainErrs + checkErrs + waitErrs;
    curName     = name;
    randomWaits = waits;
    loadImage(id);
    resetCpu();
    @(posedge clk);
    run <= 1'b1;
    // Outputs sampled away from the active edge
    do @(negedge clk); while (!halted);
    doneBefore = compareCount;
    -> compareStart;
    wait (compareCount != doneBefore);
    reportTest(errBefore);
  endtask

  task automatic resetTest();
    int errBefore;
    errBefore   = mainErrs + checkErrs + waitErrs;
    curName     = "reset";
    randomWaits = 1'b0;
    loadImage(1);
    resetCpu();
    @(negedge clk);
    assert (!psel && !penable) else begin
      $display("FAIL %0t: APB select or enable high after reset", $time);
      mainErrs++;
    end
    assert (pc == StartAddr) else begin
      $display("FAIL %0t: pc %o after reset, expected %o", $time, pc, StartAddr);
      mainErrs++;
    end
    assert (!halted) else begin
      $display("FAIL %0t: halted set after reset", $time);
      mainErrs++;
    end
    // Run held low, the bus must stay quiet
    repeat (20) begin
      @(negedge clk);
      assert (!psel) else begin
        $display("FAIL %0t: transfer started while run is low", $time);
        mainErrs++;
      end
    end
    reportTest(errBefore);
  endtask

  initial begin
    rstN        = 1'b0;
    run         = 1'b0;
    loadMem     = 1'b0;
    randomWaits = 1'b0;
    resetTest();
    runProgram("arithmetic", 1, 1'b0);
    runProgram("control", 2, 1'b0);
    runProgram("group1", 3, 1'b0);
    runProgram("group2", 4, 1'b0);
    // Same programs with random wait states
    runProgram("arithmetic with waits", 1, 1'b1);
    runProgram("control with waits", 2, 1'b1);
    runProgram("group1 with waits", 3, 1'b1);
    runProgram("group2 with waits", 4, 1'b1);
    $display("%0d tests passed, %0d tests failed, %0d check errors", passCount, failCount,
             mainErrs + checkErrs + waitErrs);
    if (failCount == 0 && mainErrs + checkErrs + waitErrs == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the PDP-8 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module pdp8Tb -f files.f -o pdp8Sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/pdp8Sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0
